//--- Makefile
# Verilator build and run of tb_mac_decoder

.PHONY: all run clean

all: run

obj_dir/Vtb_mac_decoder: verilog.f $(wildcard *.sv *.svh)
	verilator --binary --assert -Wno-fatal --top-module tb_mac_decoder -f verilog.f -Mdir obj_dir

# Pass only when the pass message shows up in the output
run: obj_dir/Vtb_mac_decoder
	@out=$$(./obj_dir/Vtb_mac_decoder); echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

//--- mac_decoder.sv
`timescale 1ns/1ns

module mac_decoder
(
	input  logic                    CLK,
	input  logic                    RST,
	input  logic [7:0]              in_data,
	input  logic                    in_data_vld,
	input  logic                    arp_done,
	input  logic                    ip_done,
	input  logic [1:0]              arp_type,
	input  logic [1:0]              ip_type,
	output logic                    arp_decoder_en,
	output logic                    ip_decoder_en,
	output mac_rx_pkg::mac_header_u mac_header,
	output mac_rx_pkg::mess_type_t  mess_type,
	output logic                    mac_done
);

	mac_rx_pkg::mac_header_u header; // Capture to dispatch
	logic                    header_valid;
	logic                    in_frame;
	logic                    busy;     // Dispatch back to capture

	// Byte stream into header
	mac_header_capture u_capture
	(
		.CLK          (CLK),
		.RST          (RST),
		.in_data      (in_data),
		.in_data_vld  (in_data_vld),
		.busy         (busy),
		.header       (header),
		.header_valid (header_valid),
		.in_frame     (in_frame)
	);

	// Classify, start peer decoder, report
	mac_decoder_dispatch u_dispatch
	(
		.CLK            (CLK),
		.RST            (RST),
		.header         (header),
		.header_valid   (header_valid),
		.in_frame       (in_frame),
		.busy           (busy),
		.arp_done       (arp_done),
		.ip_done        (ip_done),
		.arp_type       (arp_type),
		.ip_type        (ip_type),
		.arp_decoder_en (arp_decoder_en),
		.ip_decoder_en  (ip_decoder_en),
		.mac_header     (mac_header),
		.mess_type      (mess_type),
		.mac_done       (mac_done)
	);

endmodule

//--- mac_decoder_dispatch.sv
`timescale 1ns/1ns

module mac_decoder_dispatch
(
	input  logic                    CLK,
	input  logic                    RST,
	input  mac_rx_pkg::mac_header_u header,
	input  logic                    header_valid,
	input  logic                    in_frame,
	output logic                    busy,
	input  logic                    arp_done,
	input  logic                    ip_done,
	input  logic [1:0]              arp_type,
	input  logic [1:0]              ip_type,
	output logic                    arp_decoder_en,
	output logic                    ip_decoder_en,
	output mac_rx_pkg::mac_header_u mac_header,
	output mac_rx_pkg::mess_type_t  mess_type,
	output logic                    mac_done
);

	logic [2:0] state;
	logic [1:0] cls;   // Class of current header
	logic [1:0] cls_q; // Class held during the wait
	logic [1:0] sub_q; // Sub-type from the decoder
	logic       got_q; // Decoder answered before timeout
	logic [mac_rx_pkg::WAIT_CNT_W-1:0] wait_cnt;

	mac_rx_pkg::mac_fields_t hdr_f;
	logic dest_bcast;
	logic dest_local;
	logic type_arp;
	logic type_ip;
	logic done_hit;
	logic [1:0] sub_in;

	assign hdr_f = header.fields; // Header held still by capture while busy

	assign dest_bcast = (hdr_f.dest == mac_rx_pkg::BROADCAST_ADDR);
	assign dest_local = (hdr_f.dest == mac_rx_pkg::LOCAL_MAC_ADDR);
	assign type_arp   = (hdr_f.ethertype == mac_rx_pkg::ETHERTYPE_ARP) ||
		(hdr_f.ethertype == mac_rx_pkg::ETHERTYPE_RARP);
	assign type_ip    = (hdr_f.ethertype == mac_rx_pkg::ETHERTYPE_IP);

	always_comb
	begin
		cls = mac_rx_pkg::MSG_UNSUPPORTED;
		if (type_arp && (dest_bcast || dest_local))
			cls = mac_rx_pkg::MSG_ARP; // ARP and RARP, broadcast or ours
		else if (type_ip && dest_local)
			cls = mac_rx_pkg::MSG_IP;  // Unicast IP only
	end

	// Start pulses, one cycle in classify
	assign arp_decoder_en = (state == mac_rx_pkg::DSP_CLASSIFY) && (cls == mac_rx_pkg::MSG_ARP);
	assign ip_decoder_en  = (state == mac_rx_pkg::DSP_CLASSIFY) && (cls == mac_rx_pkg::MSG_IP);

	// Only the started decoder counts
	assign done_hit = (cls_q == mac_rx_pkg::MSG_ARP) ? arp_done : ip_done;
	assign sub_in   = (cls_q == mac_rx_pkg::MSG_ARP) ? arp_type : ip_type;

	// Covers header_valid cycle up to and including mac_done
	assign busy     = header_valid || (state != mac_rx_pkg::DSP_IDLE);
	assign mac_done = (state == mac_rx_pkg::DSP_DONE) && !in_frame;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state      <= mac_rx_pkg::DSP_IDLE;
			cls_q      <= mac_rx_pkg::MSG_UNSUPPORTED;
			sub_q      <= 2'd0;
			got_q      <= 1'b0;
			wait_cnt   <= '0;
			mac_header <= '0;
			mess_type  <= '0;
		end
		else
		begin
			case (state)
				mac_rx_pkg::DSP_IDLE:
					if (header_valid)
						state <= mac_rx_pkg::DSP_CLASSIFY;
				mac_rx_pkg::DSP_CLASSIFY:
				begin
					cls_q    <= cls;
					got_q    <= 1'b0;
					wait_cnt <= '0;
					// Unsupported skips the wait
					if (cls == mac_rx_pkg::MSG_UNSUPPORTED)
						state <= mac_rx_pkg::DSP_RESULT;
					else
						state <= mac_rx_pkg::DSP_WAIT;
				end
				mac_rx_pkg::DSP_WAIT:
					if (done_hit)
					begin
						sub_q <= sub_in; // Sampled on the done cycle
						got_q <= 1'b1;
						state <= mac_rx_pkg::DSP_RESULT;
					end
					else if (wait_cnt == mac_rx_pkg::WAIT_LAST)
						state <= mac_rx_pkg::DSP_RESULT; // Timeout, got_q stays low
					else
						wait_cnt <= wait_cnt + 1'b1;
				mac_rx_pkg::DSP_RESULT:
				begin
					mess_type <= '0; // Unsupported, timeout or zero sub-type
					if (got_q)
					begin
						mac_header <= header;
						if (sub_q != 2'd0)
						begin
							mess_type.sub_type  <= sub_q;
							mess_type.msg_class <= cls_q;
						end
					end
					state <= mac_rx_pkg::DSP_DONE;
				end
				mac_rx_pkg::DSP_DONE:
					if (!in_frame)
						state <= mac_rx_pkg::DSP_IDLE; // mac_done this cycle
				default:
					state <= mac_rx_pkg::DSP_IDLE;
			endcase
		end
	end

	a_one_enable: assert property (@(posedge CLK) disable iff (RST)
		!(arp_decoder_en && ip_decoder_en));

	// A dropped frame must not add a second pulse
	a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
		mac_done |=> !mac_done);

	a_class_legal: assert property (@(posedge CLK) disable iff (RST)
		mess_type.msg_class != 2'd3);

endmodule

//--- mac_header_capture.sv
`timescale 1ns/1ns

module mac_header_capture
(
	input  logic                    CLK,
	input  logic                    RST,
	input  logic [7:0]              in_data,
	input  logic                    in_data_vld,
	input  logic                    busy,         // Dispatch still owns the last header
	output mac_rx_pkg::mac_header_u header,
	output logic                    header_valid, // One cycle, header complete
	output logic                    in_frame
);

	logic [1:0] state;
	logic [3:0] byte_cnt; // Arrival index of the byte on in_data
	logic       take_byte;

	// Maps arrival order onto the union byte view
	// Dest bytes land in 5..0, source in 11..6, ethertype in 13..12
	function automatic logic [3:0] byte_slot(input logic [3:0] idx);
		logic [4:0] slot;
		if (idx < 4'd6)
			slot = 5'd5 - {1'b0, idx};
		else if (idx < 4'd12)
			slot = 5'd17 - {1'b0, idx};
		else
			slot = 5'd25 - {1'b0, idx};
		return slot[3:0];
	endfunction

	// First byte only when dispatch is free, the rest unconditionally
	assign take_byte = ((state == mac_rx_pkg::CAP_ARMED) && in_data_vld && !busy) ||
		(state == mac_rx_pkg::CAP_HEADER);

	assign in_frame = (state != mac_rx_pkg::CAP_ARMED);

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state        <= mac_rx_pkg::CAP_ARMED;
			byte_cnt     <= '0;
			header_valid <= 1'b0;
		end
		else
		begin
			header_valid <= 1'b0; // Pulse by default
			case (state)
				mac_rx_pkg::CAP_ARMED:
					if (in_data_vld)
					begin
						// Busy frame is dropped whole
						if (busy)
							state <= mac_rx_pkg::CAP_DRAIN; // Index stays at first byte
						else
						begin
							byte_cnt <= 4'd1;
							state    <= mac_rx_pkg::CAP_HEADER;
						end
					end
				mac_rx_pkg::CAP_HEADER:
				begin
					byte_cnt <= byte_cnt + 4'd1;
					if (byte_cnt == mac_rx_pkg::HDR_LAST)
					begin
						byte_cnt     <= '0;
						header_valid <= 1'b1;
						state        <= mac_rx_pkg::CAP_DRAIN;
					end
				end
				mac_rx_pkg::CAP_DRAIN:
					if (!in_data_vld)
						state <= mac_rx_pkg::CAP_ARMED; // Frame over
				default:
					state <= mac_rx_pkg::CAP_ARMED;
			endcase
		end
	end

	// Header bytes in arrival order
	always_ff @(posedge CLK)
	begin
		if (take_byte)
			header.bytes[byte_slot(byte_cnt)] <= in_data;
	end

	// Single pulse per captured header
	a_hdr_valid_pulse: assert property (@(posedge CLK) disable iff (RST)
		header_valid |=> !header_valid);

endmodule

//--- mac_rx_pkg.sv
package mac_rx_pkg;

	// Address constants
	localparam logic [47:0] BROADCAST_ADDR = 48'hFFFF_FFFF_FFFF;
	localparam logic [47:0] LOCAL_MAC_ADDR = 48'h000A_3500_0001; // 00:0A:35:00:00:01

	// Ethertypes that have a decoder behind them
	localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;
	localparam logic [15:0] ETHERTYPE_RARP = 16'h8035;
	localparam logic [15:0] ETHERTYPE_IP   = 16'h0800;

	localparam int HEADER_BYTES = 14;
	localparam logic [3:0] HDR_LAST = 4'(HEADER_BYTES - 1); // Index of last header byte

	// Decoder answer timeout, longer than a full IP frame
	localparam int WAIT_LIMIT = 1700;
	localparam int WAIT_CNT_W = $clog2(WAIT_LIMIT);
	localparam logic [WAIT_CNT_W-1:0] WAIT_LAST = WAIT_CNT_W'(WAIT_LIMIT - 1);

	// Message class codes
	localparam logic [1:0] MSG_UNSUPPORTED = 2'd0;
	localparam logic [1:0] MSG_ARP         = 2'd1;
	localparam logic [1:0] MSG_IP          = 2'd2;

	// Capture FSM
	localparam logic [1:0] CAP_ARMED  = 2'd0; // Waiting for a frame start
	localparam logic [1:0] CAP_HEADER = 2'd1; // Taking header bytes
	localparam logic [1:0] CAP_DRAIN  = 2'd2; // Skipping payload

	// Dispatch FSM
	localparam logic [2:0] DSP_IDLE     = 3'd0;
	localparam logic [2:0] DSP_CLASSIFY = 3'd1;
	localparam logic [2:0] DSP_WAIT     = 3'd2;
	localparam logic [2:0] DSP_RESULT   = 3'd3;
	localparam logic [2:0] DSP_DONE     = 3'd4;

	// Header as seen on the wire, destination sent first
	typedef struct packed {
		logic [15:0] ethertype; // Bits 111:96
		logic [47:0] src;       // Bits 95:48
		logic [47:0] dest;      // Bits 47:0
	} mac_fields_t;

	// Same 112 bits written per byte, read per field
	typedef union packed {
		mac_fields_t      fields;
		logic [13:0][7:0] bytes;
	} mac_header_u;

	typedef struct packed {
		logic [1:0] sub_type;  // From ARP or IP decoder
		logic [1:0] msg_class; // MSG_* code
	} mess_type_t;

endpackage

//--- tb_frame_tasks.svh
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		r = {r[30:0], lfsr_state[31]};
		lfsr_state = lfsr_step(lfsr_state);
	end
	return r;
endfunction

function automatic logic [47:0] rand_src();
	logic [31:0] hi;
	logic [31:0] lo;
	hi = rand_bits(16);
	lo = rand_bits(32);
	return {hi[15:0], lo};
endfunction

// Records what the DUT should report and sets up the peer
task automatic prepare_frame(input logic [47:0] dest, input logic [47:0] src,
	input logic [15:0] etype, input logic [1:0] cls, input logic answer, input logic zero_sub);
	logic [1:0] sub;
	sub         = zero_sub ? 2'd0 : 2'(1 + rand_bits(2) % 3); // Nonzero unless asked
	peer_sub    = sub;
	peer_silent = !answer;
	peer_delay  = 1 + int'(rand_bits(5) % 30);
	exp_class   = cls;
	exp_done_count++;
	if (cls != mac_rx_pkg::MSG_UNSUPPORTED)
		exp_en_count++;
	exp_mess = '0; // Unsupported, timeout or zero sub-type
	if ((cls != mac_rx_pkg::MSG_UNSUPPORTED) && answer)
	begin
		exp_header.fields.dest      = dest; // Header taken on any answer
		exp_header.fields.src       = src;
		exp_header.fields.ethertype = etype;
		if (sub != 2'd0)
		begin
			exp_mess.sub_type  = sub;
			exp_mess.msg_class = cls;
		end
	end
endtask

// Header in wire order, random payload, one idle cycle after
task automatic send_frame(input logic [47:0] dest, input logic [47:0] src,
	input logic [15:0] etype);
	logic [111:0] wire_bytes;
	int           plen;
	wire_bytes = {dest, src, etype};
	plen       = 2 + int'(rand_bits(6) % 39); // 2 to 40 bytes
	for (int i = 0; i < mac_rx_pkg::HEADER_BYTES; i++)
	begin
		@(posedge CLK);
		in_data     <= wire_bytes[111 - 8 * i -: 8];
		in_data_vld <= 1'b1;
	end
	for (int i = 0; i < plen; i++)
	begin
		@(posedge CLK);
		in_data <= 8'(rand_bits(8));
	end
	@(posedge CLK);
	in_data_vld <= 1'b0;
	in_data     <= 8'd0;
endtask

task automatic run_frame(input logic [47:0] dest, input logic [15:0] etype,
	input logic [1:0] cls, input logic answer, input logic zero_sub);
	logic [47:0] src;
	src = rand_src();
	prepare_frame(dest, src, etype, cls, answer, zero_sub);
	send_frame(dest, src, etype);
	wait_mac_done();
endtask

`endif

//--- tb_mac_decoder.sv
`timescale 1ns/1ns

module tb_mac_decoder;

	logic                    CLK;
	logic                    RST;
	logic [7:0]              in_data;
	logic                    in_data_vld;
	logic                    arp_done;
	logic                    ip_done;
	logic [1:0]              arp_type;
	logic [1:0]              ip_type;
	logic                    arp_decoder_en;
	logic                    ip_decoder_en;
	mac_rx_pkg::mac_header_u mac_header;
	mac_rx_pkg::mess_type_t  mess_type;
	logic                    mac_done;

	logic [31:0] lfsr_state = 32'hf79bbdb7;

	// Expected outcome of the frame in flight
	mac_rx_pkg::mac_header_u exp_header = '0; // Matches reset value of mac_header
	mac_rx_pkg::mess_type_t  exp_mess = '0;
	logic [1:0]              exp_class = mac_rx_pkg::MSG_UNSUPPORTED;
	int                      exp_done_count = 0;
	int                      exp_en_count = 0;
	int                      done_count;   // mac_done pulses seen
	int                      en_count;     // Decoder starts seen

	// Peer decoder behavior for the next start
	logic [1:0] peer_sub = 2'd0;
	logic       peer_silent = 1'b0;
	int         peer_delay = 1;

	mac_decoder UUT
	(
		.CLK            (CLK),
		.RST            (RST),
		.in_data        (in_data),
		.in_data_vld    (in_data_vld),
		.arp_done       (arp_done),
		.ip_done        (ip_done),
		.arp_type       (arp_type),
		.ip_type        (ip_type),
		.arp_decoder_en (arp_decoder_en),
		.ip_decoder_en  (ip_decoder_en),
		.mac_header     (mac_header),
		.mess_type      (mess_type),
		.mac_done       (mac_done)
	);

	task automatic fail_run();
		$display("Finished with errors");
		$fatal(1);
	endtask

	// Polls at the falling edge, leaves just past the pulse
	task automatic wait_mac_done();
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (!mac_done && (cycles < mac_rx_pkg::WAIT_LIMIT + 200))
		begin
			@(negedge CLK);
			cycles++;
		end
		if (!mac_done)
		begin
			$display("mac_done never came within %0d cycles", cycles);
			fail_run();
		end
		@(negedge CLK);
	endtask

	`include "tb_frame_tasks.svh"

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK; // 10 ns period
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			done_count <= 0;
			en_count   <= 0;
		end
		else
		begin
			if (mac_done)
				done_count <= done_count + 1;
			if (arp_decoder_en || ip_decoder_en)
				en_count <= en_count + 1;
		end
	end

	// Peer ARP and IP decoders
	initial
	begin
		logic answer_arp;
		arp_done = 1'b0;
		ip_done  = 1'b0;
		arp_type = 2'd0;
		ip_type  = 2'd0;
		forever
		begin
			@(negedge CLK);
			if ((arp_decoder_en || ip_decoder_en) && !peer_silent)
			begin
				answer_arp = arp_decoder_en;
				repeat (peer_delay) @(posedge CLK);
				if (answer_arp)
				begin
					arp_done <= 1'b1;
					arp_type <= peer_sub;
				end
				else
				begin
					ip_done <= 1'b1;
					ip_type <= peer_sub;
				end
				@(posedge CLK);
				arp_done <= 1'b0; // Done is a single pulse
				ip_done  <= 1'b0;
				arp_type <= 2'd0;
				ip_type  <= 2'd0;
			end
		end
	end

	a_arp_en: assert property (@(posedge CLK) disable iff (RST)
		arp_decoder_en |-> ((exp_class == mac_rx_pkg::MSG_ARP) && (en_count < exp_en_count)))
		else
		begin
			$display("arp_decoder_en pulsed when no ARP decoder start was due");
			fail_run();
		end

	a_ip_en: assert property (@(posedge CLK) disable iff (RST)
		ip_decoder_en |-> ((exp_class == mac_rx_pkg::MSG_IP) && (en_count < exp_en_count)))
		else
		begin
			$display("ip_decoder_en pulsed when no IP decoder start was due");
			fail_run();
		end

	// Dropped frames must not add a pulse
	a_done_due: assert property (@(posedge CLK) disable iff (RST)
		mac_done |-> (done_count < exp_done_count))
		else
		begin
			$display("mac_done pulsed with no frame waiting for it");
			fail_run();
		end

	a_done_starts: assert property (@(posedge CLK) disable iff (RST)
		mac_done |-> (en_count == exp_en_count))
		else
		begin
			$display("ERROR: en_count = %h, expected %h",
				$sampled(en_count), $sampled(exp_en_count));
			fail_run();
		end

	a_mess_type: assert property (@(posedge CLK) disable iff (RST)
		mac_done |-> (mess_type == exp_mess))
		else
		begin
			$display("ERROR: mess_type = %h, expected %h", $sampled(mess_type), $sampled(exp_mess));
			fail_run();
		end

	a_mac_header: assert property (@(posedge CLK) disable iff (RST)
		mac_done |-> (mac_header == exp_header))
		else
		begin
			$display("ERROR: mac_header = %h, expected %h",
				$sampled(mac_header), $sampled(exp_header));
			fail_run();
		end

	initial
	begin
		in_data     = 8'd0;
		in_data_vld = 1'b0;
		RST         = 1'b1;
		repeat (16) @(posedge CLK);
		RST <= 1'b0;
		repeat (4) @(posedge CLK);
		// ARP broadcast, RARP to us
		run_frame(mac_rx_pkg::BROADCAST_ADDR, mac_rx_pkg::ETHERTYPE_ARP, mac_rx_pkg::MSG_ARP,
			1'b1, 1'b0);
		run_frame(mac_rx_pkg::LOCAL_MAC_ADDR, mac_rx_pkg::ETHERTYPE_RARP, mac_rx_pkg::MSG_ARP,
			1'b1, 1'b0);
		run_frame(mac_rx_pkg::LOCAL_MAC_ADDR, mac_rx_pkg::ETHERTYPE_IP, mac_rx_pkg::MSG_IP,
			1'b1, 1'b0);
		// Unsupported, header must stay
		run_frame(mac_rx_pkg::BROADCAST_ADDR, mac_rx_pkg::ETHERTYPE_IP,
			mac_rx_pkg::MSG_UNSUPPORTED, 1'b1, 1'b0);
		run_frame(mac_rx_pkg::LOCAL_MAC_ADDR, 16'h86DD, mac_rx_pkg::MSG_UNSUPPORTED, 1'b1, 1'b0);
		run_frame(mac_rx_pkg::BROADCAST_ADDR, mac_rx_pkg::ETHERTYPE_ARP, mac_rx_pkg::MSG_ARP,
			1'b0, 1'b0); // Silent peer
		run_frame(mac_rx_pkg::LOCAL_MAC_ADDR, mac_rx_pkg::ETHERTYPE_IP, mac_rx_pkg::MSG_IP,
			1'b1, 1'b1); // Zero sub-type
		// Second frame lands while the first still waits
		prepare_frame(mac_rx_pkg::BROADCAST_ADDR, rand_src(), mac_rx_pkg::ETHERTYPE_ARP,
			mac_rx_pkg::MSG_ARP, 1'b1, 1'b0);
		peer_delay = 150; // Longer than two whole frames
		send_frame(exp_header.fields.dest, exp_header.fields.src, exp_header.fields.ethertype);
		send_frame(mac_rx_pkg::LOCAL_MAC_ADDR, rand_src(), mac_rx_pkg::ETHERTYPE_IP);
		wait_mac_done();
		repeat (100) @(posedge CLK); // Room for a stray pulse
		// Capture takes headers again after a dropped frame
		run_frame(mac_rx_pkg::LOCAL_MAC_ADDR, mac_rx_pkg::ETHERTYPE_IP, mac_rx_pkg::MSG_IP,
			1'b1, 1'b0);
		if ((done_count == exp_done_count) && (en_count == exp_en_count))
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
		begin
			$display("ERROR: done_count = %h, expected %h", done_count, exp_done_count);
			$display("ERROR: en_count = %h, expected %h", en_count, exp_en_count);
			fail_run();
		end
	end

endmodule

//--- verilog.f
+incdir+.
mac_rx_pkg.sv
mac_header_capture.sv
mac_decoder_dispatch.sv
mac_decoder.sv
tb_mac_decoder.sv
